// File: tb.f
+incdir+hw
hw/video_pkg.sv
hw/video_ports.sv
hw/video_sync.sv
hw/video_tsline.sv
hw/video_render.sv
hw/video_out.sv
hw/video_top.sv
verif/tb_clk.sv
verif/tb_video.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_video -o tb_video_sim

out=$(./obj_dir/tb_video_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1

// File: verif/tb_video.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module tb_video;

	import video_pkg::*;

	localparam int PIX_FRAME = `VID_H_TOTAL * `VID_V_TOTAL;
	localparam int RUN_CYC   = 6 * PIX_FRAME * 2;
	localparam int CYC_LIMIT = 8 * PIX_FRAME * 2 + 1000;
	localparam int H_LAST    = `VID_H_TOTAL - 1;
	localparam int V_LAST    = `VID_V_TOTAL - 1;

	// one pixel on its way from the render stage to the colour output
	typedef struct packed {
		pix_idx_t idx;
		logic     blank;
		logic     ok;
	} exp_pix_t;

	logic       clk;
	logic       arst_n;
	pix_idx_t   d;
	logic       border_wr;
	logic       vconf_wr;
	logic       palsel_wr;
	logic       cram_we;
	pix_idx_t   zma;
	logic [15:0] zmd;
	logic       c3;
	pix_idx_t   gfx_pix;
	ts_wr_t     ts_wr;
	logic       hsync;
	logic       vsync;
	logic       line_start_s;
	logic       int_start;
	logic [4:0] vred_raw;
	logic [4:0] vgrn_raw;
	logic [4:0] vblu_raw;
	rgb_t       got_rgb;

	// reference model state
	rgb_t       cram_m [256];
	pix_idx_t   ovl_m [2][`VID_H_ACT];
	logic       ovl_known [2][`VID_H_ACT];
	video_cfg_t cfg_m;
	logic       shadow_nogfx;
	logic       shadow_notsu;
	int         col_m;
	int         line_m;
	logic       odd_m;
	logic       stepped;
	pix_idx_t   ts_m;
	logic       ts_known;
	exp_pix_t   pipe_q [$];
	rgb_t       exp_rgb;
	logic       exp_ok;

	int   rgb_errs;
	int   sync_errs;
	int   misc_errs;
	int   ovl_hits;
	int   gfx_pixels;
	int   relatches;
	int   cyc;
	logic checking;

	tb_clk clk_gen (.clk(clk));

	video_top dut0 (.*);

	assign got_rgb = '{r: vred_raw, g: vgrn_raw, b: vblu_raw};

	task automatic check_rgb(input rgb_t exp, input rgb_t got);
		if (got !== exp) begin
			rgb_errs++;
			$display("FAIL t=%0t rgb exp %h got %h", $time, exp, got);
		end
	endtask

	task automatic check_sync(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			sync_errs++;
			$display("FAIL t=%0t %s exp %b got %b", $time, name, exp, got);
		end
	endtask

	// one clock edge of the model, using the inputs the DUT sees at this edge
	task automatic model_step();
		exp_pix_t px;
		pix_idx_t base;
		logic     hv;
		logic     ts_en;
		logic     front;
		int       x;
		if (c3) begin
			hv = (col_m >= `VID_H_ACT_BEG) && (col_m < `VID_H_ACT_BEG + `VID_H_ACT) &&
				(line_m >= `VID_V_ACT_BEG) && (line_m < `VID_V_ACT_BEG + `VID_V_ACT);
			x = col_m - `VID_H_ACT_BEG;
			front = ~odd_m;
			px.blank = (col_m < `VID_H_SYNC) || (line_m < `VID_V_SYNC);
			// shown line reads the front buffer and leaves zeros behind
			if (hv) begin
				ts_m = ovl_m[front][x];
				ts_known = ovl_known[front][x];
				ovl_m[front][x] = '0;
				ovl_known[front][x] = 1'b1;
			end
			ts_en = hv && !cfg_m.notsu;
			if (!hv || cfg_m.nogfx)
				base = cfg_m.border;
			else
				base = {cfg_m.palsel, gfx_pix[3:0]};
			px.ok = !(ts_en && !ts_known);
			if (ts_en && ts_m[3:0] != 4'd0) begin
				px.idx = ts_m;
				if (px.ok)
					ovl_hits++;
			end else begin
				px.idx = base;
				if (hv && !cfg_m.nogfx)
					gfx_pixels++;
			end
			// older pixel leaves the queue and reaches the output
			pipe_q.push_back(px);
			px = pipe_q.pop_front();
			exp_rgb = px.blank ? '0 : cram_m[px.idx];
			exp_ok = px.ok;
		end
		if (cram_we)
			cram_m[zma] = '{r: zmd[14:10], g: zmd[9:5], b: zmd[4:0]};
		if (ts_wr.we && ts_wr.addr < `VID_H_ACT) begin
			ovl_m[odd_m][ts_wr.addr] = ts_wr.data;
			ovl_known[odd_m][ts_wr.addr] = 1'b1;
		end
		if (c3 && col_m == H_LAST) begin
			if ({cfg_m.nogfx, cfg_m.notsu} != {shadow_nogfx, shadow_notsu})
				relatches++;
			cfg_m.nogfx = shadow_nogfx;
			cfg_m.notsu = shadow_notsu;
		end
		if (border_wr)
			cfg_m.border = d;
		if (palsel_wr)
			cfg_m.palsel = d[3:0];
		if (vconf_wr) begin
			shadow_nogfx = d[5];
			shadow_notsu = d[4];
		end
		if (c3) begin
			stepped = 1'b1;
			if (col_m == H_LAST) begin
				col_m = 0;
				odd_m = ~odd_m;
				line_m = (line_m == V_LAST) ? 0 : line_m + 1;
			end else begin
				col_m++;
			end
		end
	endtask

	task automatic drive_random();
		c3        <= ~c3;
		d         <= pix_idx_t'($urandom);
		border_wr <= ($urandom % 50) == 0;
		palsel_wr <= ($urandom % 50) == 0;
		vconf_wr  <= ($urandom % 200) == 0;
		cram_we   <= ($urandom % 8) == 0;
		zma       <= pix_idx_t'($urandom);
		zmd       <= 16'($urandom);
		gfx_pix   <= pix_idx_t'($urandom);
		ts_wr     <= '{we: ($urandom % 3) == 0, addr: xpos_t'($urandom),
			data: pix_idx_t'($urandom)};
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (checking) begin
			if (exp_ok)
				check_rgb(exp_rgb, got_rgb);
			check_sync("hsync", stepped && col_m < `VID_H_SYNC, hsync);
			check_sync("vsync", stepped && line_m < `VID_V_SYNC, vsync);
			check_sync("line_start_s", c3 && col_m == H_LAST, line_start_s);
			check_sync("int_start", c3 && col_m == H_LAST && line_m == V_LAST, int_start);
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYC_LIMIT) begin
			$display("timeout: the run did not end within %0d cycles", CYC_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h26d8485f));
		arst_n = 1'b1;
		d = '0;
		border_wr = 1'b0;
		vconf_wr = 1'b0;
		palsel_wr = 1'b0;
		cram_we = 1'b0;
		zma = '0;
		zmd = '0;
		c3 = 1'b0;
		gfx_pix = '0;
		ts_wr = '0;
		cfg_m = '0;
		shadow_nogfx = 1'b0;
		shadow_notsu = 1'b0;
		col_m = 0;
		line_m = 0;
		odd_m = 1'b0;
		stepped = 1'b0;
		ts_m = '0;
		ts_known = 1'b1;
		exp_rgb = '0;
		exp_ok = 1'b1;
		checking = 1'b0;
		foreach (ovl_known[i, j])
			ovl_known[i][j] = 1'b0;
		// render register after reset acts as pixel index 0, not blanked
		pipe_q.push_back('{idx: '0, blank: 1'b0, ok: 1'b1});

		@(posedge clk);
		arst_n <= 1'b0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		checking = 1'b1;

		// fill the whole colour RAM before the raster starts
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			model_step();
			cram_we <= 1'b1;
			zma <= pix_idx_t'(i);
			zmd <= 16'($urandom);
		end
		@(posedge clk);
		model_step();
		cram_we <= 1'b0;

		for (int n = 0; n < RUN_CYC; n++) begin
			@(posedge clk);
			model_step();
			drive_random();
		end
		@(posedge clk);
		model_step();

		if (ovl_hits == 0) begin
			misc_errs++;
			$display("no overlay pixel reached the screen");
		end
		if (gfx_pixels == 0) begin
			misc_errs++;
			$display("no graphics pixel reached the screen");
		end
		if (relatches == 0) begin
			misc_errs++;
			$display("no mode change was relatched at a line start");
		end
		$display("errors: rgb %0d sync %0d other %0d (overlay %0d gfx %0d relatch %0d)",
			rgb_errs, sync_errs, misc_errs, ovl_hits, gfx_pixels, relatches);
		if (rgb_errs + sync_errs + misc_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
	output logic clk
);

	// half of the 4 ns period
	localparam realtime HALF_PERIOD = 2.0;

	initial clk = 1'b0;

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: hw/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top (
	input  wire                 clk,
	input  wire                 arst_n,

	// cpu port writes
	input  video_pkg::pix_idx_t d,
	input  wire                 border_wr,
	input  wire                 vconf_wr,
	input  wire                 palsel_wr,

	// colour ram
	input  wire                 cram_we,
	input  video_pkg::pix_idx_t zma,
	input  wire          [15:0] zmd,

	// pixel strobe and sources
	input  wire                 c3,
	input  video_pkg::pix_idx_t gfx_pix,
	input  video_pkg::ts_wr_t   ts_wr,

	// syncs and pulses
	output wire                 hsync,
	output wire                 vsync,
	output wire                 line_start_s,
	output wire                 int_start,

	// raw 15 bit colour
	output wire           [4:0] vred_raw,
	output wire           [4:0] vgrn_raw,
	output wire           [4:0] vblu_raw
);

	import video_pkg::*;

	video_cfg_t cfg;
	pix_pos_t   pos;
	pix_idx_t   ts_pix;
	pix_idx_t   vplex;
	logic       blank_d;

	video_ports video_ports (
		.clk          (clk),
		.arst_n       (arst_n),
		.d            (d),
		.border_wr    (border_wr),
		.vconf_wr     (vconf_wr),
		.palsel_wr    (palsel_wr),
		.line_start_s (line_start_s),
		.cfg          (cfg)
	);

	video_sync video_sync (
		.clk          (clk),
		.arst_n       (arst_n),
		.c3           (c3),
		.hsync        (hsync),
		.vsync        (vsync),
		.line_start_s (line_start_s),
		.int_start    (int_start),
		.pos          (pos)
	);

	video_tsline video_tsline (
		.clk    (clk),
		.arst_n (arst_n),
		.c3     (c3),
		.pos    (pos),
		.ts_wr  (ts_wr),
		.ts_pix (ts_pix)
	);

	video_render video_render (
		.clk     (clk),
		.arst_n  (arst_n),
		.c3      (c3),
		.cfg     (cfg),
		.pos     (pos),
		.gfx_pix (gfx_pix),
		.ts_pix  (ts_pix),
		.vplex   (vplex),
		.blank_d (blank_d)
	);

	video_out video_out (
		.clk      (clk),
		.arst_n   (arst_n),
		.c3       (c3),
		.vplex    (vplex),
		.blank_d  (blank_d),
		.cram_we  (cram_we),
		.zma      (zma),
		.zmd      (zmd),
		.vred_raw (vred_raw),
		.vgrn_raw (vgrn_raw),
		.vblu_raw (vblu_raw)
	);

endmodule

`default_nettype wire

// File: hw/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 c3,
	input  video_pkg::pix_idx_t vplex,
	input  wire                 blank_d,
	input  wire                 cram_we,
	input  video_pkg::pix_idx_t zma,
	input  wire          [15:0] zmd,
	output logic          [4:0] vred_raw,
	output logic          [4:0] vgrn_raw,
	output logic          [4:0] vblu_raw
);

	import video_pkg::*;

	localparam int CRAM_DEPTH = 1 << $bits(pix_idx_t);

	rgb_t cram [CRAM_DEPTH];
	rgb_t cram_wdata;
	rgb_t rgb_q;

	// zmd is 0RRRRRGGGGGBBBBB
	assign cram_wdata.r = zmd[14:10];
	assign cram_wdata.g = zmd[9:5];
	assign cram_wdata.b = zmd[4:0];

	always_ff @(posedge clk) begin
		if (cram_we)
			cram[zma] <= cram_wdata;
	end

	// blanked pixels go out black
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rgb_q <= '0;
		else if (c3)
			rgb_q <= blank_d ? '0 : cram[vplex];
	end

	assign vred_raw = rgb_q.r;
	assign vgrn_raw = rgb_q.g;
	assign vblu_raw = rgb_q.b;

endmodule

`default_nettype wire

// File: hw/video_render.sv
`timescale 1ns/1ps
`default_nettype none

module video_render (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   c3,
	input  video_pkg::video_cfg_t cfg,
	input  video_pkg::pix_pos_t   pos,
	input  video_pkg::pix_idx_t   gfx_pix,
	input  video_pkg::pix_idx_t   ts_pix,
	output video_pkg::pix_idx_t   vplex,
	output logic                  blank_d
);

	import video_pkg::*;

	// border or gfx index, decided with the pixel position
	pix_idx_t base_q;
	logic     ts_en_q;
	logic     ts_hit;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			base_q  <= '0;
			ts_en_q <= 1'b0;
			blank_d <= 1'b0;
		end else if (c3) begin
			if (!pos.hvpix || cfg.nogfx)
				base_q <= cfg.border;
			else
				base_q <= {cfg.palsel, gfx_pix[3:0]};
			ts_en_q <= pos.hvpix & ~cfg.notsu;
			blank_d <= pos.blank;
		end
	end

	// overlay read lands on the same strobe as base_q
	assign ts_hit = ts_en_q && (ts_pix[3:0] != 4'd0);
	assign vplex  = ts_hit ? ts_pix : base_q;

endmodule

`default_nettype wire

// File: hw/video_tsline.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_tsline (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 c3,
	input  video_pkg::pix_pos_t pos,
	input  video_pkg::ts_wr_t   ts_wr,
	output video_pkg::pix_idx_t ts_pix
);

	import video_pkg::*;

	localparam int N_PIX = `VID_H_ACT;

	// two line buffers, role follows line parity
	pix_idx_t buf_mem [2][N_PIX];

	logic rd_stb;
	logic wr_ok;
	logic front;

	// buffer 0 is shown on odd lines
	assign front  = ~pos.line_odd;
	assign rd_stb = c3 & pos.hvpix;
	assign wr_ok  = ts_wr.we && (int'(ts_wr.addr) < N_PIX);

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (i == int'(front)) begin
				// clear behind the read
				if (rd_stb)
					buf_mem[i][pos.x] <= '0;
			end else if (wr_ok) begin
				buf_mem[i][ts_wr.addr] <= ts_wr.data;
			end
		end
	end

	// read sees the old contents
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ts_pix <= '0;
		else if (rd_stb)
			ts_pix <= buf_mem[front][pos.x];
	end

endmodule

`default_nettype wire

// File: hw/video_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_sync (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 c3,
	output logic                hsync,
	output logic                vsync,
	output logic                line_start_s,
	output logic                int_start,
	output video_pkg::pix_pos_t pos
);

	import video_pkg::*;

	localparam hcnt_t H_LAST    = hcnt_t'(`VID_H_TOTAL - 1);
	localparam vcnt_t V_LAST    = vcnt_t'(`VID_V_TOTAL - 1);
	localparam hcnt_t H_SYNC    = hcnt_t'(`VID_H_SYNC);
	localparam vcnt_t V_SYNC    = vcnt_t'(`VID_V_SYNC);
	localparam hcnt_t H_ACT_BEG = hcnt_t'(`VID_H_ACT_BEG);
	localparam hcnt_t H_ACT_END = hcnt_t'(`VID_H_ACT_BEG + `VID_H_ACT);
	localparam vcnt_t V_ACT_BEG = vcnt_t'(`VID_V_ACT_BEG);
	localparam vcnt_t V_ACT_END = vcnt_t'(`VID_V_ACT_BEG + `VID_V_ACT);

	hcnt_t hcnt;
	hcnt_t hcnt_nxt;
	vcnt_t vcnt;
	vcnt_t vcnt_nxt;
	logic  h_wrap;
	logic  v_last;
	logic  line_odd;
	logic  hpix;
	logic  vpix;

	assign h_wrap   = (hcnt == H_LAST);
	assign v_last   = (vcnt == V_LAST);
	assign hcnt_nxt = h_wrap ? '0 : hcnt + hcnt_t'(1);

	always_comb begin
		vcnt_nxt = vcnt;
		if (h_wrap)
			vcnt_nxt = v_last ? '0 : vcnt + vcnt_t'(1);
	end

	// counters only step on the pixel strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcnt     <= '0;
			vcnt     <= '0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			line_odd <= 1'b0;
		end else if (c3) begin
			hcnt  <= hcnt_nxt;
			vcnt  <= vcnt_nxt;
			hsync <= (hcnt_nxt < H_SYNC);
			vsync <= (vcnt_nxt < V_SYNC);
			if (h_wrap)
				line_odd <= ~line_odd;
		end
	end

	// pulses ride on the wrapping strobe
	assign line_start_s = c3 & h_wrap;
	assign int_start    = c3 & h_wrap & v_last;

	assign hpix = (hcnt >= H_ACT_BEG) && (hcnt < H_ACT_END);
	assign vpix = (vcnt >= V_ACT_BEG) && (vcnt < V_ACT_END);

	assign pos.blank    = (hcnt < H_SYNC) || (vcnt < V_SYNC);
	assign pos.hvpix    = hpix & vpix;
	assign pos.x        = hpix ? xpos_t'(hcnt - H_ACT_BEG) : '0;
	assign pos.line_odd = line_odd;

endmodule

`default_nettype wire

// File: hw/video_ports.sv
`timescale 1ns/1ps
`default_nettype none

module video_ports (
	input  wire                  clk,
	input  wire                  arst_n,
	input  video_pkg::pix_idx_t  d,
	input  wire                  border_wr,
	input  wire                  vconf_wr,
	input  wire                  palsel_wr,
	input  wire                  line_start_s,
	output video_pkg::video_cfg_t cfg
);

	import video_pkg::*;

	// vconf bit positions
	localparam int VCONF_NOGFX = 5;
	localparam int VCONF_NOTSU = 4;

	// mode bits as written by the cpu, not yet visible
	logic vconf_nogfx;
	logic vconf_notsu;

	// border and palsel act at once
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.border <= '0;
			cfg.palsel <= '0;
		end else begin
			if (border_wr)
				cfg.border <= d;
			if (palsel_wr)
				cfg.palsel <= d[3:0];
		end
	end

	// shadow of the mode bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vconf_nogfx <= 1'b0;
			vconf_notsu <= 1'b0;
		end else if (vconf_wr) begin
			vconf_nogfx <= d[VCONF_NOGFX];
			vconf_notsu <= d[VCONF_NOTSU];
		end
	end

	// mode change takes hold from the next line
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.nogfx <= 1'b0;
			cfg.notsu <= 1'b0;
		end else if (line_start_s) begin
			cfg.nogfx <= vconf_nogfx;
			cfg.notsu <= vconf_notsu;
		end
	end

endmodule

`default_nettype wire

// File: hw/video_pkg.sv
`default_nettype none

`include "video_cfg.svh"

package video_pkg;

	// palette index as produced by gfx, overlay and border
	typedef logic [`VID_PIX_W-1:0] pix_idx_t;

	// raster counters
	typedef logic [`VID_HCNT_W-1:0] hcnt_t;
	typedef logic [`VID_VCNT_W-1:0] vcnt_t;

	// column inside the active window
	typedef logic [`VID_X_W-1:0] xpos_t;

	typedef struct packed {
		logic [`VID_RGB_W-1:0] r;
		logic [`VID_RGB_W-1:0] g;
		logic [`VID_RGB_W-1:0] b;
	} rgb_t;

	typedef struct packed {
		pix_idx_t                border;
		logic                    nogfx;
		logic                    notsu;
		logic [`VID_PALSEL_W-1:0] palsel;
	} video_cfg_t;

	// position of the pixel being stepped
	typedef struct packed {
		logic  blank;
		logic  hvpix;
		xpos_t x;
		logic  line_odd;
	} pix_pos_t;

	// one overlay write from the sprite engine
	typedef struct packed {
		logic     we;
		xpos_t    addr;
		pix_idx_t data;
	} ts_wr_t;

endpackage

`default_nettype wire

// File: hw/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// horizontal geometry, in pixels
`define VID_H_TOTAL   40
`define VID_H_SYNC    4
`define VID_H_ACT_BEG 8
`define VID_H_ACT     24

// vertical geometry, in lines
`define VID_V_TOTAL   20
`define VID_V_SYNC    2
`define VID_V_ACT_BEG 4
`define VID_V_ACT     12

// overlay line buffer address
`define VID_X_W       5

// datapath widths
`define VID_PIX_W     8
`define VID_HCNT_W    6
`define VID_VCNT_W    5
`define VID_RGB_W     5
`define VID_PALSEL_W  4

`endif
